/* verilog/proc_pkg.sv */
`default_nettype none

package proc_pkg;

    // Default datapath sizes, overridden through the top-level parameters
    localparam int DATA_W  = 16;
    localparam int ADDR_W  = 5;

    // Instruction word is fixed by the field layout below
    localparam int INSTR_W = 34;

    // Field positions inside the instruction word, given as the lowest bit
    localparam int OPC_W   = 3;
    localparam int OPC_LO  = 31;                // Bits 33..31
    localparam int RA1_LO  = 26;                // Bits 30..26
    localparam int RA2_LO  = 21;                // Bits 25..21
    localparam int WA_LO   = 16;                // Bits 20..16
    localparam int IMM_LO  = 0;                 // Bits 15..0

    // Only the low immediate bits set the shift distance
    localparam int SHIFT_W = 4;

    typedef enum logic [OPC_W-1:0] {
        op_write       = 3'b000,                // Immediate to wa
        op_read1       = 3'b001,                // Port 1 only
        op_read2       = 3'b010,                // Both ports
        op_read1_write = 3'b011,                // Port 1 plus immediate write
        op_read2_write = 3'b100,                // Both ports plus immediate write
        op_add         = 3'b101,
        op_sub         = 3'b110,
        op_shl         = 3'b111                 // Port 1 shifted by imm
    } opcode_t;

    // ALU opcodes take the longer execute path
    function automatic logic is_alu(input opcode_t op);
        logic alu;
        alu = (op == op_add) || (op == op_sub) || (op == op_shl);
        return alu;
    endfunction

    // Both read ports are used by these opcodes
    function automatic logic reads_both(input opcode_t op);
        logic both;
        both = (op == op_read2) || (op == op_read2_write) ||
               (op == op_add) || (op == op_sub);
        return both;
    endfunction

endpackage

`default_nettype wire

/* verilog/proc_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction passed from the input side to the sequencer
interface decoded_if import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
);
    opcode_t             opcode;
    logic [addr_w-1:0]   ra1;
    logic [addr_w-1:0]   ra2;
    logic [addr_w-1:0]   wa;
    logic [data_w-1:0]   imm;
    logic                valid;                 // One-cycle pulse per accepted instruction
    logic                retire;                // Control is finished, decoder may accept again

    modport decoder (
        output opcode, ra1, ra2, wa, imm, valid,
        input  retire
    );

    modport control (
        input  opcode, ra1, ra2, wa, imm, valid,
        output retire
    );
endinterface

// Two read ports and one write port into the register file
interface regfile_if import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
);
    logic [addr_w-1:0]   ra1;
    logic [addr_w-1:0]   ra2;
    logic                re1;
    logic                re2;
    logic [addr_w-1:0]   wa;
    logic                we;
    logic [data_w-1:0]   wdata;
    logic [data_w-1:0]   rd1;                   // Valid the cycle after re1
    logic [data_w-1:0]   rd2;

    modport control (
        output ra1, ra2, re1, re2, wa, we, wdata,
        input  rd1, rd2
    );

    modport storage (
        input  ra1, ra2, re1, re2, wa, we, wdata,
        output rd1, rd2
    );
endinterface

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INSTR_W-1:0] instr,
    input  logic               instr_valid,
    output logic               busy,
    decoded_if.decoder         dec
);

    logic busy_q;
    logic accept;

    // Strobes that arrive while an instruction is in flight are dropped
    assign accept = instr_valid && !busy_q;
    assign busy   = busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= accept;                 // Single pulse per instruction
            if (accept) begin
                busy_q <= 1'b1;
            end else if (dec.retire) begin
                busy_q <= 1'b0;                  // Free again the edge after retire
            end
        end
    end

    // Fields stay put while busy, so control may read them at any step
    always_ff @(posedge clk) begin
        if (accept) begin
            dec.opcode <= opcode_t'(instr[OPC_LO +: OPC_W]);
            dec.ra1    <= instr[RA1_LO +: addr_w];
            dec.ra2    <= instr[RA2_LO +: addr_w];
            dec.wa     <= instr[WA_LO +: addr_w];
            dec.imm    <= instr[IMM_LO +: data_w];
        end
    end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
) (
    input  logic       clk,
    input  logic       rst_n,
    regfile_if.storage rf
);

    localparam int depth = 2 ** addr_w;

    logic [data_w-1:0] mem [depth];

    // Reads sample the array before the write of the same edge lands,
    // so a read and a write to one address return the old word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rf.rd1 <= '0;
            rf.rd2 <= '0;
        end else begin
            if (rf.we) begin
                mem[rf.wa] <= rf.wdata;
            end
            if (rf.re1) begin
                rf.rd1 <= mem[rf.ra1];          // Holds when port is idle
            end
            if (rf.re2) begin
                rf.rd2 <= mem[rf.ra2];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_control.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_control import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
) (
    input  logic              clk,
    input  logic              rst_n,
    decoded_if.control        dec,
    regfile_if.control        rf,
    output logic              capture,
    output logic              cap_rd1,
    output logic              cap_rd2,
    output logic              cap_alu,
    output logic [data_w-1:0] alu_res
);

    // access serves the plain read/write opcodes, execute and writeback the ALU ones
    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_execute,
        st_writeback
    } state_t;

    state_t            state;
    state_t            state_nxt;
    logic              issue;
    logic [data_w-1:0] alu_q;
    logic [data_w-1:0] alu_nxt;

    // Port accesses go out in the same cycle the decoder shows valid
    assign issue = (state == st_idle) && dec.valid;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (dec.valid) begin
                    state_nxt = is_alu(dec.opcode) ? st_execute : st_access;
                end
            end
            st_access:    state_nxt = st_idle;
            st_execute:   state_nxt = st_writeback;     // Operands back, ALU registers
            st_writeback: state_nxt = st_idle;
            default:      state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Addresses follow the held fields, only the enables are sequenced
    assign rf.ra1 = dec.ra1;
    assign rf.ra2 = dec.ra2;
    assign rf.wa  = dec.wa;

    always_comb begin
        rf.re1   = 1'b0;
        rf.re2   = 1'b0;
        rf.we    = 1'b0;
        rf.wdata = dec.imm;
        if (issue) begin
            rf.re1 = (dec.opcode != op_write);
            rf.re2 = reads_both(dec.opcode);
            rf.we  = (dec.opcode == op_write) || (dec.opcode == op_read1_write) ||
                     (dec.opcode == op_read2_write);   // Immediate write
        end
        if (state == st_writeback) begin
            rf.we    = 1'b1;
            rf.wdata = alu_q;                          // Result back to wa
        end
    end

    // Results wrap to data_w
    always_comb begin
        case (dec.opcode)
            op_add:  alu_nxt = rf.rd1 + rf.rd2;
            op_sub:  alu_nxt = rf.rd1 - rf.rd2;
            op_shl:  alu_nxt = rf.rd1 << dec.imm[SHIFT_W-1:0];
            default: alu_nxt = alu_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == st_execute) begin
            alu_q <= alu_nxt;
        end
    end

    assign alu_res = alu_q;

    // Output side loads on the last step of every opcode
    assign capture    = (state == st_access) || (state == st_writeback);
    assign dec.retire = capture;
    assign cap_alu    = (state == st_writeback);

    always_comb begin
        cap_rd1 = 1'b0;
        cap_rd2 = 1'b0;
        if (state == st_access) begin
            cap_rd1 = (dec.opcode != op_write);
            cap_rd2 = reads_both(dec.opcode);
        end
    end

endmodule

`default_nettype wire

/* verilog/result_port.sv */
`timescale 1ns/1ps
`default_nettype none

module result_port import proc_pkg::*; #(
    parameter int data_w = DATA_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              capture,
    input  logic              cap_rd1,
    input  logic              cap_rd2,
    input  logic              cap_alu,
    input  logic [data_w-1:0] rd1,
    input  logic [data_w-1:0] rd2,
    input  logic [data_w-1:0] alu_in,
    output logic [data_w-1:0] out1,
    output logic [data_w-1:0] out2,
    output logic [data_w-1:0] alu_res,
    output logic              done
);

    // Outputs only move together with done, otherwise they hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out1    <= '0;
            out2    <= '0;
            alu_res <= '0;
            done    <= 1'b0;
        end else begin
            done <= capture;                    // One-cycle pulse
            if (capture && cap_rd1) begin
                out1 <= rd1;
            end
            if (capture && cap_rd2) begin
                out2 <= rd2;
            end
            if (capture && cap_alu) begin
                alu_res <= alu_in;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/proc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module proc_top import proc_pkg::*; #(
    parameter int data_w = DATA_W,
    parameter int addr_w = ADDR_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INSTR_W-1:0] instr,
    input  logic               instr_valid,
    output logic               busy,
    output logic               done,
    output logic [data_w-1:0]  out1,
    output logic [data_w-1:0]  out2,
    output logic [data_w-1:0]  alu_res
);

    decoded_if #(.data_w(data_w), .addr_w(addr_w)) dec_bus ();
    regfile_if #(.data_w(data_w), .addr_w(addr_w)) rf_bus ();

    logic              capture;
    logic              cap_rd1;
    logic              cap_rd2;
    logic              cap_alu;
    logic [data_w-1:0] alu_value;               // Registered ALU result inside control

    instr_decoder #(.data_w(data_w), .addr_w(addr_w)) i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .dec         (dec_bus.decoder)
    );

    exec_control #(.data_w(data_w), .addr_w(addr_w)) i_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec_bus.control),
        .rf      (rf_bus.control),
        .capture (capture),
        .cap_rd1 (cap_rd1),
        .cap_rd2 (cap_rd2),
        .cap_alu (cap_alu),
        .alu_res (alu_value)
    );

    register_file #(.data_w(data_w), .addr_w(addr_w)) i_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf_bus.storage)
    );

    result_port #(.data_w(data_w)) i_result (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .cap_rd1 (cap_rd1),
        .cap_rd2 (cap_rd2),
        .cap_alu (cap_alu),
        .rd1     (rf_bus.rd1),
        .rd2     (rf_bus.rd2),
        .alu_in  (alu_value),
        .out1    (out1),
        .out2    (out2),
        .alu_res (alu_res),
        .done    (done)
    );

endmodule

`default_nettype wire

/* testbench/tb_proc_model.svh */
`ifndef TB_PROC_MODEL_SVH
`define TB_PROC_MODEL_SVH

// Reference state, updated once per accepted instruction
logic [DATA_W-1:0] model_regs [num_regs];
logic [DATA_W-1:0] model_out1;
logic [DATA_W-1:0] model_out2;
logic [DATA_W-1:0] model_alu;

task automatic model_reset();
    for (int i = 0; i < num_regs; i++) begin
        model_regs[i] = '0;
    end
    model_out1 = '0;
    model_out2 = '0;
    model_alu  = '0;
endtask

// Edges from the drive edge to done
function automatic int done_latency(input opcode_t op);
    int lat;
    case (op)
        op_add, op_sub, op_shl: lat = 4;        // Read, ALU, write-back
        default:                lat = 3;
    endcase
    return lat;
endfunction

task automatic model_apply(input opcode_t op, input logic [ADDR_W-1:0] ra1,
                           input logic [ADDR_W-1:0] ra2, input logic [ADDR_W-1:0] wa,
                           input logic [DATA_W-1:0] imm);
    logic [DATA_W-1:0] r1;
    logic [DATA_W-1:0] r2;
    r1 = model_regs[ra1];                       // Old values, before any write
    r2 = model_regs[ra2];
    case (op)
        op_write: begin
            model_regs[wa] = imm;
        end
        op_read1: begin
            model_out1 = r1;
        end
        op_read2: begin
            model_out1 = r1;
            model_out2 = r2;
        end
        op_read1_write: begin
            model_out1     = r1;
            model_regs[wa] = imm;
        end
        op_read2_write: begin
            model_out1     = r1;
            model_out2     = r2;
            model_regs[wa] = imm;
        end
        op_add: begin
            model_alu      = r1 + r2;           // Wraps to DATA_W
            model_regs[wa] = model_alu;
        end
        op_sub: begin
            model_alu      = r1 - r2;
            model_regs[wa] = model_alu;
        end
        op_shl: begin
            model_alu      = r1 << imm[SHIFT_W-1:0];
            model_regs[wa] = model_alu;
        end
        default: ;
    endcase
endtask

`endif

/* testbench/tb_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_proc import proc_pkg::*; ();

    localparam int num_regs       = 2 ** ADDR_W;
    localparam int reset_cycles   = 16;
    localparam int max_gap        = 3;
    localparam int num_random     = 400;
    localparam int num_sweep      = num_regs / 2;       // Each read2 covers two registers
    localparam int num_instr      = num_random + 2 * num_sweep;
    localparam int timeout_cycles = num_instr * (4 + max_gap + 4) + reset_cycles;

    logic               clk;
    logic               rst_n;
    logic [INSTR_W-1:0] instr;
    logic               instr_valid;
    logic               busy;
    logic               done;
    logic [DATA_W-1:0]  out1;
    logic [DATA_W-1:0]  out2;
    logic [DATA_W-1:0]  alu_res;

    integer seed;
    int     cycle_count;

    `include "tb_proc_model.svh"

    proc_top #(.data_w(DATA_W), .addr_w(ADDR_W)) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .done        (done),
        .out1        (out1),
        .out2        (out2),
        .alu_res     (alu_res)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_outputs();
        check_data("out1", out1, model_out1);
        check_data("out2", out2, model_out2);
        check_data("alu_res", alu_res, model_alu);
    endtask

    // Half the picks land in r0..r7 so reads often hit recent writes
    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0]       rnd;
        logic [ADDR_W-1:0] addr;
        rnd  = $random(seed);
        addr = rnd[ADDR_W-1:0];
        if (rnd[8]) begin
            addr[ADDR_W-1:3] = '0;
        end
        return addr;
    endfunction

    task automatic issue_instr(input opcode_t op, input logic [ADDR_W-1:0] ra1,
                               input logic [ADDR_W-1:0] ra2, input logic [ADDR_W-1:0] wa,
                               input logic [DATA_W-1:0] imm);
        int          lat;
        logic [31:0] rnd;
        lat = done_latency(op);
        @(posedge clk);
        instr       <= {op, ra1, ra2, wa, imm};
        instr_valid <= 1'b1;
        for (int k = 1; k <= lat; k++) begin
            @(posedge clk);
            rnd = $random(seed);
            instr       <= {rnd[1:0], rnd};     // Junk word for the dropped strobes
            // Sampled while busy still holds, so never accepted
            instr_valid <= (k < lat) ? rnd[2] : 1'b0;
            @(negedge clk);
            if (k == lat) begin
                model_apply(op, ra1, ra2, wa, imm);
            end
            check_flag("busy", busy, k < lat);
            check_flag("done", done, k == lat);
            check_outputs();                    // Hold until done, then new values
        end
    endtask

    task automatic idle_cycles(input logic [1:0] n);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_outputs();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        abort_run();
    end

    initial begin
        logic [31:0] rnd;
        opcode_t     op;
        seed        = 32'hf539e270;
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_outputs();

        // Every register reads back zero after reset
        for (int i = 0; i < num_sweep; i++) begin
            issue_instr(op_read2, ADDR_W'(2 * i), ADDR_W'(2 * i + 1), '0, '0);
        end

        for (int n = 0; n < num_random; n++) begin
            rnd = $random(seed);
            op  = opcode_t'(rnd[2:0]);
            issue_instr(op, pick_addr(), pick_addr(), pick_addr(), rnd[31 -: DATA_W]);
            idle_cycles(rnd[4:3]);
        end

        // Final register contents against the model
        for (int i = 0; i < num_sweep; i++) begin
            issue_instr(op_read2, ADDR_W'(2 * i), ADDR_W'(2 * i + 1), '0, '0);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+testbench
verilog/proc_pkg.sv
verilog/proc_ifs.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/exec_control.sv
verilog/result_port.sv
verilog/proc_top.sv
testbench/tb_proc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide the result from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_proc -f sim.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_proc >> sim.log 2>&1

cat sim.log

grep -qx "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
